// ==== proc_ctrl_pkg.sv ====
// ---------------------------------------------------------------------
// shared encodings and stage bundles for the pipelined control unit
// imported by the stage modules and the top level
// ---------------------------------------------------------------------
`default_nettype none

package proc_ctrl_pkg;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;

  // ---------------------------------------------------------------------
  // rv32 opcode and funct encodings matched by the decoder
  // ---------------------------------------------------------------------
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // alu funct3, shared by reg and imm forms
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // word access and csr forms
  localparam logic [2:0] f3_lw    = 3'b010;
  localparam logic [2:0] f3_sw    = 3'b010;
  localparam logic [2:0] f3_csrrw = 3'b001;
  localparam logic [2:0] f3_csrrs = 3'b010;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // manager csrs
  localparam logic [11:0] csr_mngr2proc_c = 12'hFC0;
  localparam logic [11:0] csr_proc2mngr_c = 12'h7C0;

  // ---------------------------------------------------------------------
  // select encodings toward the datapath
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {pc_plus4, pc_jal, pc_branch, pc_jalr} pc_sel_e;
  typedef enum logic [1:0] {byp_w, byp_rf, byp_m, byp_x} bypass_sel_e;
  typedef enum logic [1:0] {op2_rf, op2_imm, op2_mngr} op2_sel_e;
  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;

  // codes 2 and 14..15 unused
  typedef enum logic [3:0] {
    alu_add = 4'd0, alu_sub = 4'd1, alu_and = 4'd3, alu_or = 4'd4,
    alu_xor = 4'd5, alu_slt = 4'd6, alu_sltu = 4'd7, alu_sra = 4'd8,
    alu_srl = 4'd9, alu_sll = 4'd10, alu_cp0 = 4'd11, alu_cp1 = 4'd12,
    alu_jalr_add = 4'd13
  } alu_fn_e;

  typedef enum logic [2:0] {
    br_none, br_bne, br_beq, br_blt, br_bltu, br_bge, br_bgeu
  } br_type_e;

  typedef enum logic [1:0] {jump_none, jump_jal, jump_jalr} jump_type_e;
  typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_type_e;
  typedef enum logic {ex_pc4, ex_alu} ex_sel_e;

  // ---------------------------------------------------------------------
  // stage bundles
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic       valid;
    alu_fn_e    alu_fn;
    br_type_e   br_type;
    jump_type_e jump_type;
    mem_type_e  mem_type;
    ex_sel_e    ex_sel;
    logic       wb_from_mem;
    logic       rf_wen;
    reg_addr_t  rf_waddr;
    logic       proc2mngr;
  } d2x_t;

  typedef struct packed {
    logic      valid;
    mem_type_e mem_type;
    logic      wb_from_mem;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    logic      proc2mngr;
  } x2m_t;

  // destination report back to decode for bypass and hazard checks
  typedef struct packed {
    logic      valid;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    logic      is_load;
    logic      ready_for_bypass;
  } dest_t;

  typedef struct packed {
    logic    taken;
    pc_sel_e target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== ctrl_fetch_decode.sv ====
// ---------------------------------------------------------------------
// F and D stage control: imem handshake, pc select, control table,
// bypass selects and decode stalls
// ---------------------------------------------------------------------
`default_nettype none

module ctrl_fetch_decode (
  input  wire logic                      clk,
  input  wire logic                      reset,
  output logic                           imemreq_val_o,
  input  wire logic                      imemresp_val_i,
  output logic                           imemresp_rdy_o,
  output logic                           imemresp_drop_o,
  output logic                           reg_en_f_o,
  output proc_ctrl_pkg::pc_sel_e         pc_sel_f_o,
  input  wire proc_ctrl_pkg::inst_t      inst_d_i,
  output logic                           reg_en_d_o,
  output proc_ctrl_pkg::bypass_sel_e     op1_bp_sel_d_o,
  output proc_ctrl_pkg::bypass_sel_e     op2_bp_sel_d_o,
  output logic                           op1_sel_d_o,
  output proc_ctrl_pkg::op2_sel_e        op2_sel_d_o,
  output proc_ctrl_pkg::imm_type_e       imm_type_d_o,
  input  wire logic                      mngr2proc_val_i,
  output logic                           mngr2proc_rdy_o,
  output proc_ctrl_pkg::d2x_t            d2x_o,
  input  wire proc_ctrl_pkg::dest_t      dest_x_i,
  input  wire proc_ctrl_pkg::dest_t      dest_m_i,
  input  wire proc_ctrl_pkg::dest_t      dest_w_i,
  input  wire proc_ctrl_pkg::redirect_t  redirect_x_i,
  input  wire logic                      hold_x_i
);
  import proc_ctrl_pkg::*;

  logic       val_f, val_d;
  logic       stall_f, squash_f, stall_d, squash_d, ostall_d;
  logic       next_val_f, next_val_d, jal_redirect_d;
  reg_addr_t  rs1, rs2;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       rs1_en, rs2_en, csrr_d, csrw_d, rf_wen_d, wb_mem_d;
  jump_type_e jump_d;
  br_type_e   br_d;
  alu_fn_e    alu_fn_d;
  ex_sel_e    ex_sel_d;
  mem_type_e  mem_d;
  logic       hit1_x, hit1_m, hit1_w, hit2_x, hit2_m, hit2_w;

  // register write in a later stage that matches a source
  function automatic logic hit(dest_t d, reg_addr_t rs, logic en);
    hit = en && d.valid && d.rf_wen && (d.rf_waddr != 5'd0) && (d.rf_waddr == rs);
  endfunction

  // youngest producer wins
  function automatic bypass_sel_e pick(logic hx, logic hm, logic hw);
    pick = hx ? byp_x : hm ? byp_m : hw ? byp_w : byp_rf;
  endfunction

  function automatic alu_fn_e alu_of(logic [2:0] fn3, logic alt, logic is_reg);
    case (fn3)
      f3_add:  alu_of = (alt && is_reg) ? alu_sub : alu_add;
      f3_sll:  alu_of = alu_sll;
      f3_slt:  alu_of = alu_slt;
      f3_sltu: alu_of = alu_sltu;
      f3_xor:  alu_of = alu_xor;
      f3_sr:   alu_of = alt ? alu_sra : alu_srl;
      f3_or:   alu_of = alu_or;
      default: alu_of = alu_and;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // F stage
  // ---------------------------------------------------------------------
  assign stall_f  = (val_f && !imemresp_val_i) || stall_d;
  assign squash_f = jal_redirect_d || redirect_x_i.taken;
  assign reg_en_f_o = !stall_f || squash_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (reg_en_f_o) begin
      val_f <= 1'b1;
    end
  end

  // X redirect beats JAL in D
  assign pc_sel_f_o = redirect_x_i.taken ? redirect_x_i.target :
                      jal_redirect_d     ? pc_jal : pc_plus4;

  // no request while in reset
  assign imemreq_val_o   = reg_en_f_o && !reset;
  assign imemresp_rdy_o  = reg_en_f_o;
  assign imemresp_drop_o = val_f && squash_f;
  assign next_val_f      = val_f && !stall_f && !squash_f;

  // ---------------------------------------------------------------------
  // D stage
  // ---------------------------------------------------------------------
  assign reg_en_d_o = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d_o) begin
      val_d <= next_val_f;
    end
  end

  assign rs1 = inst_d_i[19:15];
  assign rs2 = inst_d_i[24:20];
  assign f3  = inst_d_i[14:12];
  assign f7  = inst_d_i[31:25];

  // control table, anything unmatched acts as a nop
  always_comb begin
    jump_d = jump_none;
    br_d = br_none;
    imm_type_d_o = imm_i;
    op1_sel_d_o = 1'b1;
    op2_sel_d_o = op2_imm;
    rs1_en = 1'b0;
    rs2_en = 1'b0;
    alu_fn_d = alu_add;
    ex_sel_d = ex_alu;
    mem_d = mem_none;
    wb_mem_d = 1'b0;
    rf_wen_d = 1'b0;
    csrr_d = 1'b0;
    csrw_d = 1'b0;
    case (inst_d_i[6:0])
      op_lui: begin
        imm_type_d_o = imm_u;
        alu_fn_d = alu_cp1;
        rf_wen_d = 1'b1;
      end
      op_auipc: begin
        // pc on operand 1
        imm_type_d_o = imm_u;
        op1_sel_d_o = 1'b0;
        rf_wen_d = 1'b1;
      end
      op_imm: begin
        rs1_en = 1'b1;
        alu_fn_d = alu_of(f3, f7 == f7_alt, 1'b0);
        rf_wen_d = 1'b1;
      end
      op_reg: begin
        if (f7 == f7_base || f7 == f7_alt) begin
          op2_sel_d_o = op2_rf;
          rs1_en = 1'b1;
          rs2_en = 1'b1;
          alu_fn_d = alu_of(f3, f7 == f7_alt, 1'b1);
          rf_wen_d = 1'b1;
        end
      end
      op_load: begin
        if (f3 == f3_lw) begin
          rs1_en = 1'b1;
          mem_d = mem_load;
          wb_mem_d = 1'b1;
          rf_wen_d = 1'b1;
        end
      end
      op_store: begin
        if (f3 == f3_sw) begin
          imm_type_d_o = imm_s;
          rs1_en = 1'b1;
          rs2_en = 1'b1;
          mem_d = mem_store;
        end
      end
      op_jal: begin
        jump_d = jump_jal;
        imm_type_d_o = imm_j;
        ex_sel_d = ex_pc4;
        rf_wen_d = 1'b1;
      end
      op_jalr: begin
        jump_d = jump_jalr;
        rs1_en = 1'b1;
        alu_fn_d = alu_jalr_add;
        ex_sel_d = ex_pc4;
        rf_wen_d = 1'b1;
      end
      op_branch: begin
        imm_type_d_o = imm_b;
        op2_sel_d_o = op2_rf;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        case (f3)
          f3_beq:  br_d = br_beq;
          f3_bne:  br_d = br_bne;
          f3_blt:  br_d = br_blt;
          f3_bge:  br_d = br_bge;
          f3_bltu: br_d = br_bltu;
          f3_bgeu: br_d = br_bgeu;
          default: br_d = br_none;
        endcase
      end
      op_system: begin
        if (f3 == f3_csrrs && inst_d_i[31:20] == csr_mngr2proc_c) begin
          // manager word passes the alu on operand 2
          op2_sel_d_o = op2_mngr;
          alu_fn_d = alu_cp1;
          rf_wen_d = 1'b1;
          csrr_d = 1'b1;
        end else if (f3 == f3_csrrw && inst_d_i[31:20] == csr_proc2mngr_c) begin
          rs1_en = 1'b1;
          alu_fn_d = alu_cp0;
          csrw_d = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // bypass selects
  assign hit1_x = hit(dest_x_i, rs1, rs1_en);
  assign hit1_m = hit(dest_m_i, rs1, rs1_en);
  assign hit1_w = hit(dest_w_i, rs1, rs1_en);
  assign hit2_x = hit(dest_x_i, rs2, rs2_en);
  assign hit2_m = hit(dest_m_i, rs2, rs2_en);
  assign hit2_w = hit(dest_w_i, rs2, rs2_en);
  assign op1_bp_sel_d_o = pick(hit1_x, hit1_m, hit1_w);
  assign op2_bp_sel_d_o = pick(hit2_x, hit2_m, hit2_w);

  // load in X has no data yet, nor a load in M still waiting on dmem
  assign ostall_d = val_d && ((hit1_x || hit2_x) && dest_x_i.is_load
                  || (hit1_m || hit2_m) && !dest_m_i.ready_for_bypass
                  || csrr_d && !mngr2proc_val_i);
  assign stall_d  = ostall_d || hold_x_i;
  assign squash_d = redirect_x_i.taken;

  // fires once, when the JAL leaves D
  assign jal_redirect_d  = val_d && (jump_d == jump_jal) && !stall_d && !squash_d;
  assign mngr2proc_rdy_o = val_d && csrr_d && !stall_d && !squash_d;
  assign next_val_d      = val_d && !stall_d && !squash_d;

  always_comb begin
    d2x_o.valid       = next_val_d;
    d2x_o.alu_fn      = alu_fn_d;
    d2x_o.br_type     = br_d;
    d2x_o.jump_type   = jump_d;
    d2x_o.mem_type    = mem_d;
    d2x_o.ex_sel      = ex_sel_d;
    d2x_o.wb_from_mem = wb_mem_d;
    d2x_o.rf_wen      = rf_wen_d;
    d2x_o.rf_waddr    = inst_d_i[11:7];
    d2x_o.proc2mngr   = csrw_d;
  end

endmodule

`default_nettype wire

// ==== ctrl_execute.sv ====
// ---------------------------------------------------------------------
// X stage control: branch and jalr resolution, dmem request
// ---------------------------------------------------------------------
`default_nettype none

module ctrl_execute (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire proc_ctrl_pkg::d2x_t    d2x_i,
  input  wire logic                   br_eq_x_i,
  input  wire logic                   br_lt_x_i,
  input  wire logic                   br_ltu_x_i,
  output logic                        reg_en_x_o,
  output proc_ctrl_pkg::alu_fn_e      alu_fn_x_o,
  output proc_ctrl_pkg::ex_sel_e      ex_result_sel_x_o,
  output logic                        dmemreq_val_o,
  input  wire logic                   dmemreq_rdy_i,
  output logic                        mem_wen_o,
  input  wire logic                   hold_m_i,
  output logic                        hold_x_o,
  output proc_ctrl_pkg::redirect_t    redirect_x_o,
  output proc_ctrl_pkg::dest_t        dest_x_o,
  output proc_ctrl_pkg::x2m_t         x2m_o
);
  import proc_ctrl_pkg::*;

  d2x_t x_q;
  logic br_cond;
  logic has_mem;

  assign reg_en_x_o = !hold_x_o;

  // only valid carries a reset
  always_ff @(posedge clk) begin
    if (reset) begin
      x_q.valid <= 1'b0;
    end else if (reg_en_x_o) begin
      x_q <= d2x_i;
    end
  end

  assign alu_fn_x_o        = x_q.alu_fn;
  assign ex_result_sel_x_o = x_q.ex_sel;
  assign mem_wen_o         = x_q.mem_type == mem_store;
  assign has_mem           = x_q.mem_type != mem_none;

  // branch condition from datapath compare bits
  always_comb begin
    case (x_q.br_type)
      br_bne:  br_cond = !br_eq_x_i;
      br_beq:  br_cond = br_eq_x_i;
      br_blt:  br_cond = br_lt_x_i;
      br_bltu: br_cond = br_ltu_x_i;
      br_bge:  br_cond = !br_lt_x_i;
      br_bgeu: br_cond = !br_ltu_x_i;
      default: br_cond = 1'b0;
    endcase
  end

  // stalls from dmem request or anything ahead
  assign hold_x_o = (x_q.valid && has_mem && !dmemreq_rdy_i) || hold_m_i;

  // a held X would otherwise squash twice
  assign redirect_x_o.taken  = x_q.valid && !hold_x_o
                               && (br_cond || x_q.jump_type == jump_jalr);
  assign redirect_x_o.target = (x_q.jump_type == jump_jalr) ? pc_jalr : pc_branch;

  assign dmemreq_val_o = x_q.valid && !hold_x_o && has_mem;

  always_comb begin
    dest_x_o.valid            = x_q.valid;
    dest_x_o.rf_wen           = x_q.rf_wen;
    dest_x_o.rf_waddr         = x_q.rf_waddr;
    dest_x_o.is_load          = x_q.mem_type == mem_load;
    dest_x_o.ready_for_bypass = x_q.mem_type != mem_load;
  end

  always_comb begin
    x2m_o.valid       = x_q.valid && !hold_x_o;
    x2m_o.mem_type    = x_q.mem_type;
    x2m_o.wb_from_mem = x_q.wb_from_mem;
    x2m_o.rf_wen      = x_q.rf_wen;
    x2m_o.rf_waddr    = x_q.rf_waddr;
    x2m_o.proc2mngr   = x_q.proc2mngr;
  end

endmodule

`default_nettype wire

// ==== ctrl_result.sv ====
// ---------------------------------------------------------------------
// M and W stage control: dmem response, register write, manager
// output and commit
// ---------------------------------------------------------------------
`default_nettype none

module ctrl_result (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire proc_ctrl_pkg::x2m_t   x2m_i,
  output logic                       reg_en_m_o,
  output logic                       wb_result_sel_m_o,
  input  wire logic                  dmemresp_val_i,
  output logic                       dmemresp_rdy_o,
  output logic                       reg_en_w_o,
  output proc_ctrl_pkg::reg_addr_t   rf_waddr_w_o,
  output logic                       rf_wen_w_o,
  output logic                       proc2mngr_val_o,
  input  wire logic                  proc2mngr_rdy_i,
  output logic                       commit_o,
  output logic                       hold_m_o,
  output proc_ctrl_pkg::dest_t       dest_m_o,
  output proc_ctrl_pkg::dest_t       dest_w_o
);
  import proc_ctrl_pkg::*;

  x2m_t m_q, w_q, next_w;
  logic ostall_w;
  logic has_mem;

  // ---------------------------------------------------------------------
  // M stage
  // ---------------------------------------------------------------------
  assign reg_en_m_o = !hold_m_o;

  always_ff @(posedge clk) begin
    if (reset) begin
      m_q.valid <= 1'b0;
    end else if (reg_en_m_o) begin
      m_q <= x2m_i;
    end
  end

  assign has_mem           = m_q.mem_type != mem_none;
  assign wb_result_sel_m_o = m_q.wb_from_mem;

  // wait for the response, or for W
  assign hold_m_o       = (m_q.valid && has_mem && !dmemresp_val_i) || ostall_w;
  assign dmemresp_rdy_o = m_q.valid && !hold_m_o && has_mem;

  always_comb begin
    next_w       = m_q;
    next_w.valid = m_q.valid && !hold_m_o;
  end

  // load data usable once taken from dmem
  always_comb begin
    dest_m_o.valid            = m_q.valid;
    dest_m_o.rf_wen           = m_q.rf_wen;
    dest_m_o.rf_waddr         = m_q.rf_waddr;
    dest_m_o.is_load          = m_q.mem_type == mem_load;
    dest_m_o.ready_for_bypass = !dest_m_o.is_load || dmemresp_rdy_o;
  end

  // ---------------------------------------------------------------------
  // W stage
  // ---------------------------------------------------------------------
  assign reg_en_w_o = !ostall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      w_q.valid <= 1'b0;
    end else if (reg_en_w_o) begin
      w_q <= next_w;
    end
  end

  // csrw waits for manager ready
  assign ostall_w        = w_q.valid && w_q.proc2mngr && !proc2mngr_rdy_i;
  assign rf_waddr_w_o    = w_q.rf_waddr;
  assign rf_wen_w_o      = w_q.valid && w_q.rf_wen;
  assign proc2mngr_val_o = w_q.valid && w_q.proc2mngr && !ostall_w;
  assign commit_o        = w_q.valid && !ostall_w;

  always_comb begin
    dest_w_o.valid            = w_q.valid;
    dest_w_o.rf_wen           = w_q.rf_wen;
    dest_w_o.rf_waddr         = w_q.rf_waddr;
    dest_w_o.is_load          = w_q.mem_type == mem_load;
    dest_w_o.ready_for_bypass = 1'b1;
  end

endmodule

`default_nettype wire

// ==== proc_ctrl.sv ====
// ---------------------------------------------------------------------
// control unit top: ties fetch/decode, execute and result stages
// ---------------------------------------------------------------------
`default_nettype none

module proc_ctrl (
  input  wire logic                  clk,
  input  wire logic                  reset,
  // imem
  output logic                       imemreq_val_o,
  input  wire logic                  imemresp_val_i,
  output logic                       imemresp_rdy_o,
  output logic                       imemresp_drop_o,
  // dmem
  output logic                       dmemreq_val_o,
  input  wire logic                  dmemreq_rdy_i,
  output logic                       mem_wen_o,
  input  wire logic                  dmemresp_val_i,
  output logic                       dmemresp_rdy_o,
  // manager
  input  wire logic                  mngr2proc_val_i,
  output logic                       mngr2proc_rdy_o,
  output logic                       proc2mngr_val_o,
  input  wire logic                  proc2mngr_rdy_i,
  // selects and enables to datapath
  output logic                       reg_en_f_o,
  output proc_ctrl_pkg::pc_sel_e     pc_sel_f_o,
  output logic                       reg_en_d_o,
  output proc_ctrl_pkg::bypass_sel_e op1_bp_sel_d_o,
  output proc_ctrl_pkg::bypass_sel_e op2_bp_sel_d_o,
  output logic                       op1_sel_d_o,
  output proc_ctrl_pkg::op2_sel_e    op2_sel_d_o,
  output proc_ctrl_pkg::imm_type_e   imm_type_d_o,
  output logic                       reg_en_x_o,
  output proc_ctrl_pkg::alu_fn_e     alu_fn_x_o,
  output proc_ctrl_pkg::ex_sel_e     ex_result_sel_x_o,
  output logic                       reg_en_m_o,
  output logic                       wb_result_sel_m_o,
  output logic                       reg_en_w_o,
  output proc_ctrl_pkg::reg_addr_t   rf_waddr_w_o,
  output logic                       rf_wen_w_o,
  output logic                       commit_o,
  // status from datapath
  input  wire proc_ctrl_pkg::inst_t  inst_d_i,
  input  wire logic                  br_eq_x_i,
  input  wire logic                  br_lt_x_i,
  input  wire logic                  br_ltu_x_i
);
  import proc_ctrl_pkg::*;

  d2x_t      d2x;
  x2m_t      x2m;
  dest_t     dest_x, dest_m, dest_w;
  redirect_t redirect_x;
  logic      hold_x, hold_m;

  ctrl_fetch_decode u_fd (
    .clk(clk), .reset(reset),
    .imemreq_val_o(imemreq_val_o), .imemresp_val_i(imemresp_val_i),
    .imemresp_rdy_o(imemresp_rdy_o), .imemresp_drop_o(imemresp_drop_o),
    .reg_en_f_o(reg_en_f_o), .pc_sel_f_o(pc_sel_f_o), .inst_d_i(inst_d_i),
    .reg_en_d_o(reg_en_d_o), .op1_bp_sel_d_o(op1_bp_sel_d_o),
    .op2_bp_sel_d_o(op2_bp_sel_d_o), .op1_sel_d_o(op1_sel_d_o),
    .op2_sel_d_o(op2_sel_d_o), .imm_type_d_o(imm_type_d_o),
    .mngr2proc_val_i(mngr2proc_val_i), .mngr2proc_rdy_o(mngr2proc_rdy_o),
    .d2x_o(d2x), .dest_x_i(dest_x), .dest_m_i(dest_m), .dest_w_i(dest_w),
    .redirect_x_i(redirect_x), .hold_x_i(hold_x)
  );

  ctrl_execute u_ex (
    .clk(clk), .reset(reset), .d2x_i(d2x),
    .br_eq_x_i(br_eq_x_i), .br_lt_x_i(br_lt_x_i), .br_ltu_x_i(br_ltu_x_i),
    .reg_en_x_o(reg_en_x_o), .alu_fn_x_o(alu_fn_x_o),
    .ex_result_sel_x_o(ex_result_sel_x_o), .dmemreq_val_o(dmemreq_val_o),
    .dmemreq_rdy_i(dmemreq_rdy_i), .mem_wen_o(mem_wen_o),
    .hold_m_i(hold_m), .hold_x_o(hold_x), .redirect_x_o(redirect_x),
    .dest_x_o(dest_x), .x2m_o(x2m)
  );

  ctrl_result u_res (
    .clk(clk), .reset(reset), .x2m_i(x2m),
    .reg_en_m_o(reg_en_m_o), .wb_result_sel_m_o(wb_result_sel_m_o),
    .dmemresp_val_i(dmemresp_val_i), .dmemresp_rdy_o(dmemresp_rdy_o),
    .reg_en_w_o(reg_en_w_o), .rf_waddr_w_o(rf_waddr_w_o), .rf_wen_w_o(rf_wen_w_o),
    .proc2mngr_val_o(proc2mngr_val_o), .proc2mngr_rdy_i(proc2mngr_rdy_i),
    .commit_o(commit_o), .hold_m_o(hold_m),
    .dest_m_o(dest_m), .dest_w_o(dest_w)
  );

endmodule

`default_nettype wire

// ==== tb_proc_ctrl.sv ====
// ----------------------------------------------------------------------
// testbench for the pipelined control unit that feeds instruction words,
// drives the memory and manager handshakes and checks with assertions
// ----------------------------------------------------------------------
`default_nettype none

module tb_proc_ctrl;
  import proc_ctrl_pkg::*;

  localparam int    clk_period = 40;
  // step count that sizes the watchdog
  localparam int    num_insts  = 110;
  localparam inst_t nop_w      = 32'h0;

  logic        clk, reset;
  logic        imemreq_val_o, imemresp_val_i, imemresp_rdy_o, imemresp_drop_o;
  logic        dmemreq_val_o, dmemreq_rdy_i, mem_wen_o, dmemresp_val_i, dmemresp_rdy_o;
  logic        mngr2proc_val_i, mngr2proc_rdy_o, proc2mngr_val_o, proc2mngr_rdy_i;
  logic        reg_en_f_o, reg_en_d_o, op1_sel_d_o, reg_en_x_o, reg_en_m_o;
  logic        wb_result_sel_m_o, reg_en_w_o, rf_wen_w_o, commit_o;
  pc_sel_e     pc_sel_f_o;
  bypass_sel_e op1_bp_sel_d_o, op2_bp_sel_d_o;
  op2_sel_e    op2_sel_d_o;
  imm_type_e   imm_type_d_o;
  alu_fn_e     alu_fn_x_o;
  ex_sel_e     ex_result_sel_x_o;
  reg_addr_t   rf_waddr_w_o;
  inst_t       inst_d_i;
  logic        br_eq_x_i, br_lt_x_i, br_ltu_x_i;

  int          seed;
  reg_addr_t   r_a;
  logic [11:0] imm;
  inst_t       marker;

  proc_ctrl uut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // watchdog
  initial begin
    #(clk_period * (num_insts + 50));
    $display("watchdog: simulation ran past its time limit");
    $display("Test FAILED");
    $fatal(1);
  end

  // ----------------------------------------------------------------------
  // checkers
  // ----------------------------------------------------------------------
  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Mismatch %s: expected %0h actual %0h", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // x31 is only written by squashed markers
  always @(negedge clk) begin
    if (!reset) begin
      assert (!(commit_o && rf_wen_w_o && rf_waddr_w_o == 5'd31)) else begin
        $display("a squashed instruction writing x31 reached commit");
        $display("Test FAILED");
        $fatal(1);
      end
    end
  end

  // ----------------------------------------------------------------------
  // instruction encoders and stimulus
  // ----------------------------------------------------------------------
  function automatic inst_t r_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic inst_t i_word(logic [11:0] im, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] op);
    return {im, rs1, f3, rd, op};
  endfunction

  function automatic inst_t s_word(logic [11:0] im, reg_addr_t rs2, reg_addr_t rs1);
    return {im[11:5], rs2, rs1, f3_sw, im[4:0], op_store};
  endfunction

  // branch offset of 8
  function automatic inst_t b_word(reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
    return {7'b0, rs2, rs1, f3, 5'b01000, op_branch};
  endfunction

  // jump offset of 8
  function automatic inst_t j_word(reg_addr_t rd);
    return {1'b0, 10'b0000000100, 1'b0, 8'b0, rd, op_jal};
  endfunction

  // nonzero register other than the marker's x31
  function automatic reg_addr_t rand_reg();
    reg_addr_t r;
    r = reg_addr_t'($random(seed));
    if (r == 5'd0 || r == 5'd31) r = 5'd1;
    return r;
  endfunction

  task automatic drive(input inst_t inst);
    @(posedge clk);
    #2;
    inst_d_i = inst;
  endtask

  // drive and wait for stable outputs
  task automatic step(input inst_t inst);
    drive(inst);
    @(negedge clk);
  endtask

  task automatic flush();
    repeat (4) step(nop_w);
  endtask

  // alu op checked in D, X, M and W
  task automatic alu_case(input string name, input inst_t inst, input reg_addr_t rd,
                          input alu_fn_e fn, input op2_sel_e op2);
    step(inst);
    expect_eq({name, " reg_en_d"}, 32'd1, 32'(reg_en_d_o));
    expect_eq({name, " fetch enables"}, 32'd3, 32'({reg_en_f_o, imemresp_rdy_o}));
    expect_eq({name, " op1_sel"}, 32'd1, 32'(op1_sel_d_o));
    expect_eq({name, " op2_sel"}, 32'(op2), 32'(op2_sel_d_o));
    step(nop_w);
    expect_eq({name, " alu_fn"}, 32'(fn), 32'(alu_fn_x_o));
    expect_eq({name, " ex_sel"}, 32'(ex_alu), 32'(ex_result_sel_x_o));
    expect_eq({name, " reg_en_x"}, 32'd1, 32'(reg_en_x_o));
    step(nop_w);
    expect_eq({name, " reg_en_m"}, 32'd1, 32'(reg_en_m_o));
    expect_eq({name, " wb_sel"}, 32'd0, 32'(wb_result_sel_m_o));
    step(nop_w);
    expect_eq({name, " rf_wen"}, 32'd1, 32'(rf_wen_w_o));
    expect_eq({name, " rf_waddr"}, 32'(rd), 32'(rf_waddr_w_o));
    expect_eq({name, " commit"}, 32'd1, 32'(commit_o));
  endtask

  // producer gap instructions ahead of the consumer
  task automatic bypass_case(input string name, input int gap, input bypass_sel_e sel);
    r_a = rand_reg();
    step(i_word(12'd5, 5'd1, f3_add, r_a, op_imm));
    repeat (gap - 1) step(nop_w);
    step(r_word(f7_base, 5'd0, r_a, f3_add, 5'd2));
    expect_eq({name, " op1"}, 32'(sel), 32'(op1_bp_sel_d_o));
    expect_eq({name, " op2 x0"}, 32'(byp_rf), 32'(op2_bp_sel_d_o));
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    seed = 32'h121084dd;
    reset = 1'b1;
    inst_d_i = nop_w;
    imemresp_val_i = 1'b1;
    dmemreq_rdy_i = 1'b1;
    dmemresp_val_i = 1'b1;
    mngr2proc_val_i = 1'b1;
    proc2mngr_rdy_i = 1'b1;
    br_eq_x_i = 1'b0;
    br_lt_x_i = 1'b0;
    br_ltu_x_i = 1'b0;
    marker = i_word(12'd1, 5'd1, f3_add, 5'd31, op_imm);
    // idle outputs through the reset cycles
    @(posedge clk);
    repeat (2) begin
      @(negedge clk);
      expect_eq("reset idle", 32'd0, 32'({imemreq_val_o, dmemreq_val_o, dmemresp_rdy_o,
        mngr2proc_rdy_o, proc2mngr_val_o, rf_wen_w_o, commit_o, imemresp_drop_o}));
      @(posedge clk);
    end
    #2 reset = 1'b0;
    @(negedge clk);
    expect_eq("after reset", 32'd0, 32'({dmemreq_val_o, dmemresp_rdy_o, mngr2proc_rdy_o,
      proc2mngr_val_o, rf_wen_w_o, commit_o, imemresp_drop_o}));
    flush();

    // decode
    r_a = rand_reg();
    imm = 12'($random(seed));
    alu_case("addi", i_word(imm, 5'd1, f3_add, r_a, op_imm), r_a, alu_add, op2_imm);
    r_a = rand_reg();
    alu_case("sub", r_word(f7_alt, 5'd2, 5'd1, f3_add, r_a), r_a, alu_sub, op2_rf);
    r_a = rand_reg();
    alu_case("srai", i_word({7'b0100000, 5'd3}, 5'd1, f3_sr, r_a, op_imm), r_a,
             alu_sra, op2_imm);
    step({20'h12345, 5'd3, op_auipc});
    expect_eq("auipc op1_sel", 32'd0, 32'(op1_sel_d_o));
    expect_eq("auipc imm_type", 32'(imm_u), 32'(imm_type_d_o));
    step(s_word(imm, 5'd2, 5'd1));
    expect_eq("sw imm_type", 32'(imm_s), 32'(imm_type_d_o));
    step(nop_w);
    expect_eq("sw mem_wen", 32'd1, 32'(mem_wen_o));
    step(nop_w);
    step(nop_w);
    expect_eq("sw rf_wen", 32'd0, 32'(rf_wen_w_o));
    flush();

    // bypass and load-use
    bypass_case("byp one ahead", 1, byp_x);
    bypass_case("byp two ahead", 2, byp_m);
    bypass_case("byp three ahead", 3, byp_w);
    step(i_word(12'd5, 5'd1, f3_add, 5'd0, op_imm));
    step(r_word(f7_base, 5'd0, 5'd0, f3_add, 5'd2));
    expect_eq("x0 read", 32'(byp_rf), 32'(op1_bp_sel_d_o));
    flush();
    r_a = rand_reg();
    step(i_word(12'd0, 5'd1, f3_lw, r_a, op_load));
    step(r_word(f7_base, 5'd0, r_a, f3_add, 5'd2));
    expect_eq("load-use stall", 32'd0, 32'(reg_en_d_o));
    expect_eq("load-use fetch hold", 32'd0, 32'({reg_en_f_o, imemresp_rdy_o}));
    expect_eq("load dmemreq_val", 32'd1, 32'(dmemreq_val_o));
    step(r_word(f7_base, 5'd0, r_a, f3_add, 5'd2));
    expect_eq("load-use release", 32'd1, 32'(reg_en_d_o));
    expect_eq("load-use bypass", 32'(byp_m), 32'(op1_bp_sel_d_o));
    expect_eq("load wb_sel", 32'd1, 32'(wb_result_sel_m_o));
    expect_eq("load dmemresp_rdy", 32'd1, 32'(dmemresp_rdy_o));
    flush();

    // redirect
    step(b_word(5'd2, 5'd1, f3_beq));
    drive(marker);
    br_eq_x_i = 1'b1;
    @(negedge clk);
    expect_eq("beq taken pc_sel", 32'(pc_branch), 32'(pc_sel_f_o));
    expect_eq("beq taken drop", 32'd1, 32'(imemresp_drop_o));
    drive(nop_w);
    br_eq_x_i = 1'b0;
    flush();
    step(b_word(5'd2, 5'd1, f3_beq));
    expect_eq("beq imm_type", 32'(imm_b), 32'(imm_type_d_o));
    step(nop_w);
    expect_eq("beq not taken pc_sel", 32'(pc_plus4), 32'(pc_sel_f_o));
    expect_eq("beq not taken drop", 32'd0, 32'(imemresp_drop_o));
    flush();
    step(j_word(5'd0));
    expect_eq("jal pc_sel", 32'(pc_jal), 32'(pc_sel_f_o));
    step(marker);
    flush();
    step(i_word(12'd0, 5'd1, 3'b000, 5'd0, op_jalr));
    step(marker);
    expect_eq("jalr pc_sel", 32'(pc_jalr), 32'(pc_sel_f_o));
    expect_eq("jalr ex_sel", 32'(ex_pc4), 32'(ex_result_sel_x_o));
    flush();

    // manager back-pressure on csrw in W
    proc2mngr_rdy_i = 1'b0;
    step(i_word(csr_proc2mngr_c, 5'd1, f3_csrrw, 5'd0, op_system));
    repeat (3) step(nop_w);
    repeat (2) begin
      expect_eq("csrw held reg_en", 32'd0, 32'({reg_en_f_o, reg_en_d_o, reg_en_x_o,
        reg_en_m_o, reg_en_w_o}));
      expect_eq("csrw held proc2mngr_val", 32'd0, 32'(proc2mngr_val_o));
      expect_eq("csrw held commit", 32'd0, 32'(commit_o));
      step(nop_w);
    end
    drive(nop_w);
    proc2mngr_rdy_i = 1'b1;
    @(negedge clk);
    expect_eq("csrw proc2mngr_val", 32'd1, 32'(proc2mngr_val_o));
    expect_eq("csrw commit", 32'd1, 32'(commit_o));
    flush();

    // csrr waits for manager input
    mngr2proc_val_i = 1'b0;
    r_a = rand_reg();
    repeat (2) begin
      step(i_word(csr_mngr2proc_c, 5'd0, f3_csrrs, r_a, op_system));
      expect_eq("csrr waiting", 32'd0, 32'(reg_en_d_o));
    end
    drive(i_word(csr_mngr2proc_c, 5'd0, f3_csrrs, r_a, op_system));
    mngr2proc_val_i = 1'b1;
    @(negedge clk);
    expect_eq("csrr accepted", 32'd1, 32'(reg_en_d_o));
    expect_eq("csrr mngr2proc_rdy", 32'd1, 32'(mngr2proc_rdy_o));
    flush();

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
proc_ctrl_pkg.sv
ctrl_fetch_decode.sv
ctrl_execute.sv
ctrl_result.sv
proc_ctrl.sv
tb_proc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_proc_ctrl -o sim_proc_ctrl

./obj_dir/sim_proc_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
exit 1
